//--- Makefile
TOP := tb_minmax_slice

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

//--- bench/tb_minmax_slice.sv
`timescale 1ns/1ps

module tb_minmax_slice;
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  localparam int unsigned PIPE_REGS  = 2;
  localparam int unsigned N_PER_TEST = 40;
  localparam int unsigned TOTAL_TXN  = 6 * N_PER_TEST + 2 * PIPE_REGS;

  typedef struct packed {
    word_t       result;
    status_t     status;
    tag_t        tag;
    logic [31:0] cycle;   // Edge on which the request was taken
  } expect_t;

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  word_t      a_i, b_i, result_o;
  fp_format_e fmt_i;
  minmax_op_e op_i;
  logic       vectorial_op_i, in_valid_i, in_ready_o, flush_i;
  tag_t       tag_i, tag_o;
  lane_mask_t simd_mask_i;
  status_t    status_o;
  logic       out_valid_o, out_ready_i, busy_o;

  logic [31:0] lfsr_state   = 32'hdd91_70a2;
  logic [31:0] cycle_count  = '0;
  int unsigned accept_count = 0;
  int unsigned error_count  = 0;
  int unsigned test_count   = 0;
  int unsigned ready_mode   = 0;   // 0 high, 1 random, 2 low
  expect_t     sb_q [$];

  always #5 clk_i = ~clk_i;

  minmax_slice #(.NumPipeRegs(PIPE_REGS)) uut (.*);

  // --------------------------------------------------
  // Random source
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int unsigned n, output word_t v);
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Random float of width w with specials mixed in
  task automatic rand_value(input int unsigned w, output word_t v);
    word_t pick, bits, sign, exp_ones, quiet;
    take_bits(3, pick);
    take_bits(w, bits);
    sign     = 32'h1 << (w - 1);
    exp_ones = (w == 32) ? 32'h7f80_0000 : 32'h0000_7c00;
    quiet    = (w == 32) ? 32'h0040_0000 : 32'h0000_0200;
    case (pick[2:0])
      3'd0:    v = bits & sign;                                 // Signed zero
      3'd1:    v = (bits & sign) | exp_ones;                    // Infinity
      3'd2:    v = (bits & sign) | exp_ones | quiet | (bits & (quiet - 32'h1));
      3'd3:    v = (bits & sign) | exp_ones | (bits & (quiet - 32'h1)) | 32'h1;
      default: v = bits;
    endcase
  endtask

  task automatic rand_operand(input fp_format_e fmt, output word_t v);
    word_t lo, hi;
    if (fmt == FP32) begin
      rand_value(32, v);
    end else begin
      rand_value(16, lo);
      rand_value(16, hi);
      v = {hi[15:0], lo[15:0]};
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // One lane of width w returning {nv, result}
  function automatic logic [32:0] ref_lane(input word_t a, b, input int unsigned w,
                                           input minmax_op_e op);
    word_t sign, mask, exp_ones, quiet, key_a, key_b, res;
    logic  nan_a, nan_b, snan;
    sign     = 32'h1 << (w - 1);
    mask     = (w == 32) ? 32'hffff_ffff : 32'h0000_ffff;
    exp_ones = (w == 32) ? 32'h7f80_0000 : 32'h0000_7c00;
    quiet    = (w == 32) ? 32'h0040_0000 : 32'h0000_0200;
    nan_a    = (a & ~sign & mask) > exp_ones;
    nan_b    = (b & ~sign & mask) > exp_ones;
    snan     = (nan_a && (a & quiet) == 0) || (nan_b && (b & quiet) == 0);
    key_a    = ((a & sign) != 0) ? (~a & mask) : (a | sign);   // Total order key
    key_b    = ((b & sign) != 0) ? (~b & mask) : (b | sign);
    if (nan_a && nan_b) res = (w == 32) ? CANON_NAN32 : {16'h0, CANON_NAN16};
    else if (nan_a)     res = b;
    else if (nan_b)     res = a;
    else if (op == OP_MIN) res = (key_a < key_b) ? a : b;
    else                res = (key_a > key_b) ? a : b;
    return {snan, res};
  endfunction

  function automatic expect_t ref_minmax(input word_t a, b, input fp_format_e fmt,
                                         input minmax_op_e op, input logic vec,
                                         input lane_mask_t mask);
    logic [32:0] lo, hi;
    expect_t     e;
    e = '0;
    if (fmt == FP32) begin
      lo          = ref_lane(a, b, 32, op);
      e.result    = lo[31:0];
      e.status.nv = lo[32] & mask[0];
    end else begin
      lo = ref_lane({16'h0, a[15:0]}, {16'h0, b[15:0]}, 16, op);
      hi = vec ? ref_lane({16'h0, a[31:16]}, {16'h0, b[31:16]}, 16, op) : {1'b0, 32'hffff};
      e.result    = {hi[15:0], lo[15:0]};
      e.status.nv = (lo[32] & mask[0]) | (hi[32] & mask[1]);
    end
    return e;
  endfunction

  // --------------------------------------------------
  // Comparators and scoreboard
  // --------------------------------------------------
  task automatic check_result(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      error_count++;
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t want);
    if (got !== want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      error_count++;
    end
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t want);
    if (got !== want) begin
      $display("MISMATCH %s got %h expected %h", name, got, want);
      error_count++;
    end
  endtask

  always @(posedge clk_i) begin : scoreboard
    expect_t item;
    if (rst_n_i && flush_i) begin
      sb_q.delete();   // Flushed items never come out
    end else if (rst_n_i) begin
      if (out_valid_o && out_ready_i) begin
        if (sb_q.size() == 0) begin
          $display("Output handshake with no request pending, tag %h", tag_o);
          error_count++;
        end else begin
          item = sb_q.pop_front();
          check_result("result_o", result_o, item.result);
          check_status("status_o", status_o, item.status);
          check_tag("tag_o", tag_o, item.tag);
          if (ready_mode == 0 && cycle_count - item.cycle != PIPE_REGS) begin
            $display("Latency was %0d cycles instead of %0d", cycle_count - item.cycle,
                     PIPE_REGS);
            error_count++;
          end
        end
      end
      if (in_valid_i && in_ready_o) begin
        item       = ref_minmax(a_i, b_i, fmt_i, op_i, vectorial_op_i, simd_mask_i);
        item.tag   = tag_i;
        item.cycle = cycle_count;
        sb_q.push_back(item);
        accept_count++;
      end
    end
    cycle_count <= cycle_count + 1;
  end

  // --------------------------------------------------
  // Stimulus tasks called on falling edges
  // --------------------------------------------------
  task automatic step_ready();
    word_t r;
    if (ready_mode == 1) begin
      take_bits(1, r);
      out_ready_i = r[0];
    end else begin
      out_ready_i = (ready_mode == 0);
    end
  endtask

  task automatic issue(input word_t a, b, input fp_format_e fmt, input minmax_op_e op,
                       input logic vec, input lane_mask_t mask);
    int unsigned start;
    start          = accept_count;
    a_i            = a;
    b_i            = b;
    fmt_i          = fmt;
    op_i           = op;
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    tag_i          = tag_i + 1'b1;
    in_valid_i     = 1'b1;
    do begin
      @(negedge clk_i);
      step_ready();
    end while (accept_count == start);   // Held until the DUT takes it
    in_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (sb_q.size() != 0) begin
      @(negedge clk_i);
      step_ready();
    end
  endtask

  // Values 0 and 1 of fmt_sel and vec_sel are fixed and 2 is random
  // vec_sel 3 sets vec only for FP32
  task automatic run_test(input string name, input int unsigned fmt_sel,
                          input int unsigned vec_sel, input logic mask_rand);
    word_t       a, b, r;
    fp_format_e  fmt;
    minmax_op_e  op;
    logic        vec;
    lane_mask_t  mask;
    int unsigned errs;
    errs = error_count;
    for (int unsigned i = 0; i < N_PER_TEST; i++) begin
      take_bits(6, r);
      fmt  = (fmt_sel == 2) ? fp_format_e'(r[0]) : fp_format_e'(fmt_sel[0]);
      vec  = (vec_sel == 2) ? r[1] : (vec_sel == 3) ? (fmt == FP32) : vec_sel[0];
      mask = mask_rand ? lane_mask_t'(r[3:2]) : 2'b11;
      op   = minmax_op_e'(r[4]);
      rand_operand(fmt, a);
      rand_operand(fmt, b);
      if (mask_rand && r[5]) a[31:16] = 16'h7d01;   // Signaling NaN in one lane
      else if (mask_rand) a[15:0] = 16'h7d01;
      if (fmt_sel == 0 && i < 4) begin   // Opposite signed zeros for min and max
        a  = {i[0], 31'h0};
        b  = {~i[0], 31'h0};
        op = minmax_op_e'(i[1]);
      end
      issue(a, b, fmt, op, vec, mask);
    end
    drain();
    test_count++;
    $display("Test %s: %0d transactions, %0d errors", name, N_PER_TEST, error_count - errs);
  endtask

  task automatic flush_test();
    word_t       a, b;
    int unsigned errs;
    errs       = error_count;
    ready_mode = 2;
    for (int unsigned i = 0; i < PIPE_REGS; i++) begin   // Fill every stage
      rand_operand(FP16, a);
      rand_operand(FP16, b);
      issue(a, b, FP16, OP_MAX, 1'b1, 2'b11);
    end
    if (!out_valid_o || !busy_o || in_ready_o) begin
      $display("Pipeline did not report full with every stage holding an item");
      error_count++;
    end
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    if (out_valid_o || busy_o) begin
      $display("Items still in flight one cycle after flush");
      error_count++;
    end
    ready_mode = 0;
    step_ready();
    for (int unsigned i = 0; i < PIPE_REGS; i++) begin
      rand_operand(FP32, a);
      rand_operand(FP32, b);
      issue(a, b, FP32, OP_MIN, 1'b0, 2'b11);
    end
    drain();
    test_count++;
    $display("Test flush: %0d transactions, %0d errors", 2 * PIPE_REGS, error_count - errs);
  endtask

  initial begin : main
    rst_n_i        = 1'b0;
    a_i            = '0;
    b_i            = '0;
    fmt_i          = FP32;
    op_i           = OP_MIN;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '1;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    if (!in_ready_o || out_valid_o || busy_o) begin
      $display("Handshake outputs are wrong after reset");
      error_count++;
    end
    run_test("fp32", 0, 0, 1'b0);
    run_test("vec_fp16", 1, 1, 1'b0);
    run_test("scalar_fp16", 2, 3, 1'b0);
    run_test("simd_mask", 1, 1, 1'b1);
    ready_mode = 1;
    run_test("backpressure", 2, 2, 1'b0);
    ready_mode = 0;
    run_test("latency", 2, 2, 1'b0);
    flush_test();
    $display("Tests %0d, errors %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (TOTAL_TXN * (PIPE_REGS + 20)) @(posedge clk_i);
    $display("Timeout, the tests did not complete in the expected time");
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- sim.f
source/fp_fmt_pkg.sv
source/slice_op_pkg.sv
source/lane_req_if.sv
source/lane_rsp_if.sv
source/slice_dispatch.sv
source/minmax_lane.sv
source/result_assembler.sv
source/minmax_slice.sv
bench/tb_minmax_slice.sv

//--- source/fp_fmt_pkg.sv
package fp_fmt_pkg;

  // --------------------------------------------------
  // Float formats handled by the slice
  // --------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;
  localparam int unsigned NUM_LANES  = 2; // Lane 1 only for vectorial FP16

  typedef logic [FP32_WIDTH-1:0] word_t; // Full datapath word
  typedef logic [FP16_WIDTH-1:0] half_t; // One FP16 lane

  // Quiet NaN with zero payload, positive sign
  localparam word_t CANON_NAN32 = 32'h7fc0_0000;
  localparam half_t CANON_NAN16 = 16'h7e00;

  // IEEE exception flags, min/max only ever raises nv
  typedef struct packed {
    logic nv; // Invalid operation
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

endpackage

//--- source/lane_req_if.sv
`timescale 1ns/1ps

interface lane_req_if;
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  logic       valid;
  logic       ready;
  word_t      a;    // Upper bits ignored for FP16
  word_t      b;
  fp_format_e fmt;
  minmax_op_e op;
  tag_t       tag;
  logic       mask; // Own SIMD mask bit
  aux_t       aux;

  // Dispatcher side
  modport dispatch (
    output valid, a, b, fmt, op, tag, mask, aux,
    input  ready
  );

  // Lane side
  modport lane (
    input  valid, a, b, fmt, op, tag, mask, aux,
    output ready
  );

endinterface

//--- source/lane_rsp_if.sv
`timescale 1ns/1ps

interface lane_rsp_if;
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  logic    valid;
  logic    ready;
  word_t   result;
  status_t status;
  logic    mask;
  tag_t    tag;
  aux_t    aux;
  logic    busy;   // Any stage of the lane holds an item

  // Lane side
  modport lane (
    output valid, result, status, mask, tag, aux, busy,
    input  ready
  );

  // Assembler side
  modport assemble (
    input  valid, result, status, mask, tag, aux, busy,
    output ready
  );

endinterface

//--- source/minmax_lane.sv
`timescale 1ns/1ps

module minmax_lane #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        flush_i,
  lane_req_if.lane    req_i,
  lane_rsp_if.lane    rsp_o
);
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  half_t                 a_h, b_h;
  logic                  sign_a, sign_b;
  logic [FP32_WIDTH-2:0] mag_a, mag_b;
  logic                  nan_a, nan_b;
  logic                  snan_a, snan_b;
  logic                  a_lt_b, pick_a;
  word_t                 result_d;
  status_t               status_d;

  // --------------------------------------------------
  // Operand classification
  // --------------------------------------------------
  always_comb begin : classify
    a_h = req_i.a[FP16_WIDTH-1:0];
    b_h = req_i.b[FP16_WIDTH-1:0];
    if (req_i.fmt == FP16) begin
      sign_a = a_h[15];
      sign_b = b_h[15];
      mag_a  = {{(FP32_WIDTH-FP16_WIDTH){1'b0}}, a_h[FP16_WIDTH-2:0]};
      mag_b  = {{(FP32_WIDTH-FP16_WIDTH){1'b0}}, b_h[FP16_WIDTH-2:0]};
      nan_a  = (&a_h[14:10]) & (|a_h[9:0]);   // Exponent all ones, mantissa set
      nan_b  = (&b_h[14:10]) & (|b_h[9:0]);
      snan_a = nan_a & ~a_h[9];               // Quiet bit clear
      snan_b = nan_b & ~b_h[9];
    end else begin
      sign_a = req_i.a[31];
      sign_b = req_i.b[31];
      mag_a  = req_i.a[FP32_WIDTH-2:0];
      mag_b  = req_i.b[FP32_WIDTH-2:0];
      nan_a  = (&req_i.a[30:23]) & (|req_i.a[22:0]);
      nan_b  = (&req_i.b[30:23]) & (|req_i.b[22:0]);
      snan_a = nan_a & ~req_i.a[22];
      snan_b = nan_b & ~req_i.b[22];
    end
  end

  // Sign first, so -0 sorts below +0 without a zero check
  assign a_lt_b = (sign_a != sign_b) ? sign_a :
                  sign_a             ? (mag_a > mag_b) : (mag_a < mag_b);
  assign pick_a = (req_i.op == OP_MIN) ? a_lt_b : ~a_lt_b;

  always_comb begin : select_result
    if (nan_a & nan_b) begin
      result_d = (req_i.fmt == FP16) ? {{FP16_WIDTH{1'b1}}, CANON_NAN16} : CANON_NAN32;
    end else if (nan_a) begin
      result_d = req_i.b; // Single NaN yields the other operand
    end else if (nan_b) begin
      result_d = req_i.a;
    end else begin
      result_d = pick_a ? req_i.a : req_i.b;
    end
    status_d    = '0;
    status_d.nv = snan_a | snan_b;
  end

  // --------------------------------------------------
  // Register pipeline, entry i holds the item after i stages
  // --------------------------------------------------
  logic    pipe_valid_q  [0:NumPipeRegs];
  logic    pipe_ready    [0:NumPipeRegs];
  word_t   pipe_result_q [0:NumPipeRegs];
  status_t pipe_status_q [0:NumPipeRegs];
  tag_t    pipe_tag_q    [0:NumPipeRegs];
  logic    pipe_mask_q   [0:NumPipeRegs];
  aux_t    pipe_aux_q    [0:NumPipeRegs];

  assign pipe_valid_q[0]  = req_i.valid;
  assign pipe_result_q[0] = result_d;
  assign pipe_status_q[0] = status_d;
  assign pipe_tag_q[0]    = req_i.tag;
  assign pipe_mask_q[0]   = req_i.mask;
  assign pipe_aux_q[0]    = req_i.aux;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic reg_ena;

    // Advance when the next stage is empty or moving on
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];
    assign reg_ena       = pipe_ready[i] & pipe_valid_q[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        pipe_result_q[i+1] <= pipe_result_q[i];
        pipe_status_q[i+1] <= pipe_status_q[i];
        pipe_tag_q[i+1]    <= pipe_tag_q[i];
        pipe_mask_q[i+1]   <= pipe_mask_q[i];
        pipe_aux_q[i+1]    <= pipe_aux_q[i];
      end
    end
  end

  assign pipe_ready[NumPipeRegs] = rsp_o.ready; // Backpressure from the assembler
  assign req_i.ready             = pipe_ready[0];

  assign rsp_o.valid  = pipe_valid_q[NumPipeRegs];
  assign rsp_o.result = pipe_result_q[NumPipeRegs];
  assign rsp_o.status = pipe_status_q[NumPipeRegs];
  assign rsp_o.tag    = pipe_tag_q[NumPipeRegs];
  assign rsp_o.mask   = pipe_mask_q[NumPipeRegs];
  assign rsp_o.aux    = pipe_aux_q[NumPipeRegs];

  always_comb begin : busy_collect
    rsp_o.busy = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      rsp_o.busy = rsp_o.busy | pipe_valid_q[i];
    end
  end

endmodule

//--- source/minmax_slice.sv
`timescale 1ns/1ps

module minmax_slice #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Operation
  input  fp_fmt_pkg::word_t          a_i,
  input  fp_fmt_pkg::word_t          b_i,
  input  fp_fmt_pkg::fp_format_e     fmt_i,
  input  slice_op_pkg::minmax_op_e   op_i,
  input  logic                       vectorial_op_i,
  input  slice_op_pkg::tag_t         tag_i,
  input  slice_op_pkg::lane_mask_t   simd_mask_i,
  // Input handshake
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       flush_i,
  // Result
  output fp_fmt_pkg::word_t          result_o,
  output fp_fmt_pkg::status_t        status_o,
  output slice_op_pkg::tag_t         tag_o,
  // Output handshake
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic                       busy_o
);

  lane_req_if lane0_req ();
  lane_req_if lane1_req ();
  lane_rsp_if lane0_rsp ();
  lane_rsp_if lane1_rsp ();

  slice_dispatch u_dispatch (
    .a_i            ( a_i            ),
    .b_i            ( b_i            ),
    .fmt_i          ( fmt_i          ),
    .op_i           ( op_i           ),
    .vectorial_op_i ( vectorial_op_i ),
    .tag_i          ( tag_i          ),
    .simd_mask_i    ( simd_mask_i    ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .lane0_o        ( lane0_req      ),
    .lane1_o        ( lane1_req      )
  );

  // --------------------------------------------------
  // Lanes run side by side in lockstep
  // --------------------------------------------------
  minmax_lane #(.NumPipeRegs(NumPipeRegs)) u_lane0 (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .flush_i ( flush_i   ),
    .req_i   ( lane0_req ),
    .rsp_o   ( lane0_rsp )
  );

  minmax_lane #(.NumPipeRegs(NumPipeRegs)) u_lane1 (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .flush_i ( flush_i   ),
    .req_i   ( lane1_req ),
    .rsp_o   ( lane1_rsp )
  );

  result_assembler u_assemble (
    .lane0_i     ( lane0_rsp   ),
    .lane1_i     ( lane1_rsp   ),
    .out_ready_i ( out_ready_i ),
    .out_valid_o ( out_valid_o ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .busy_o      ( busy_o      )
  );

endmodule

//--- source/result_assembler.sv
`timescale 1ns/1ps

module result_assembler (
  lane_rsp_if.assemble            lane0_i,
  lane_rsp_if.assemble            lane1_i,
  input  logic                    out_ready_i,
  output logic                    out_valid_o,
  output fp_fmt_pkg::word_t       result_o,
  output fp_fmt_pkg::status_t     status_o,
  output slice_op_pkg::tag_t      tag_o,
  output logic                    busy_o
);
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  logic       result_is_vector;
  fp_format_e result_fmt;
  logic       lane1_valid;
  half_t      upper_half;
  status_t    lane0_status, lane1_status;

  // --------------------------------------------------
  // Decode from lane 0, the upper lane only follows it
  // --------------------------------------------------
  assign result_is_vector = lane0_i.aux[AUX_VEC_IDX];
  assign result_fmt       = fp_format_e'(lane0_i.aux[AUX_FMT_IDX]);

  // Handshake on lane 1 only during vector results
  assign lane0_i.ready = out_ready_i;
  assign lane1_i.ready = out_ready_i & result_is_vector;
  assign lane1_valid   = lane1_i.valid & result_is_vector;

  // --------------------------------------------------
  // Result packing
  // --------------------------------------------------
  assign upper_half = lane1_valid ? lane1_i.result[FP16_WIDTH-1:0] : '1; // NaN-box

  assign result_o = (result_fmt == FP16) ?
                    {upper_half, lane0_i.result[FP16_WIDTH-1:0]} : lane0_i.result;

  // Masked lanes contribute no flags
  assign lane0_status = lane0_i.status &
                        {$bits(status_t){lane0_i.valid & lane0_i.mask}};
  assign lane1_status = lane1_i.status &
                        {$bits(status_t){lane1_valid & lane1_i.mask}};

  assign status_o = lane0_status | lane1_status;

  assign out_valid_o = lane0_i.valid;
  assign tag_o       = lane0_i.tag;
  assign busy_o      = lane0_i.busy | lane1_i.busy;

endmodule

//--- source/slice_dispatch.sv
`timescale 1ns/1ps

module slice_dispatch (
  input  fp_fmt_pkg::word_t          a_i,
  input  fp_fmt_pkg::word_t          b_i,
  input  fp_fmt_pkg::fp_format_e     fmt_i,
  input  slice_op_pkg::minmax_op_e   op_i,
  input  logic                       vectorial_op_i,
  input  slice_op_pkg::tag_t         tag_i,
  input  slice_op_pkg::lane_mask_t   simd_mask_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  lane_req_if.dispatch               lane0_o,
  lane_req_if.dispatch               lane1_o
);
  import fp_fmt_pkg::*;
  import slice_op_pkg::*;

  logic vec_op;
  aux_t aux;

  // Vector operations exist for FP16 only
  assign vec_op = vectorial_op_i & (fmt_i == FP16);

  always_comb begin : build_aux
    aux              = '0;
    aux[AUX_VEC_IDX] = vec_op;
    aux[AUX_FMT_IDX] = fmt_i;
  end

  // --------------------------------------------------
  // Lane 0, always in use
  // --------------------------------------------------
  assign lane0_o.valid = in_valid_i;
  assign lane0_o.a     = a_i;
  assign lane0_o.b     = b_i;
  assign lane0_o.fmt   = fmt_i;
  assign lane0_o.op    = op_i;
  assign lane0_o.tag   = tag_i;
  assign lane0_o.mask  = simd_mask_i[0];
  assign lane0_o.aux   = aux;

  // --------------------------------------------------
  // Lane 1, upper half-words
  // --------------------------------------------------
  // Lane 1 may be empty while lane 0 is full, so it only
  // takes a request on the edge lane 0 takes it too
  assign lane1_o.valid = in_valid_i & vec_op & lane0_o.ready;
  assign lane1_o.a     = a_i >> FP16_WIDTH;
  assign lane1_o.b     = b_i >> FP16_WIDTH;
  assign lane1_o.fmt   = fmt_i;
  assign lane1_o.op    = op_i;
  assign lane1_o.tag   = tag_i;
  assign lane1_o.mask  = simd_mask_i[1];
  assign lane1_o.aux   = aux;

  assign in_ready_o = lane0_o.ready; // Upstream ready from lane 0

endmodule

//--- source/slice_op_pkg.sv
package slice_op_pkg;

  typedef enum logic {
    OP_MIN = 1'b0,
    OP_MAX = 1'b1
  } minmax_op_e;

  typedef logic [3:0] tag_t;

  // One mask bit per SIMD lane
  typedef logic [fp_fmt_pkg::NUM_LANES-1:0] lane_mask_t;

  // Side data travelling with each lane operation
  typedef logic [1:0] aux_t;

  // Bit positions inside aux_t
  localparam int unsigned AUX_VEC_IDX = 1; // Effective vector flag
  localparam int unsigned AUX_FMT_IDX = 0; // Operation format

endpackage
